// File: dv/cp0Tests.txt
// test ctl cause ext num pc wdata jmp addr read mask (hex). ctl nibbles: fetchExc fetchBD
// decodeExc decodeBD memExc memBD cp0Write. pc is memPC. mask: 1 jump, 2 jumpAddress, 4 read.
01 0000000 00 00 0C 00000000 00000000 0 00000000 0000FF02 5
01 0000000 00 00 0E 00000000 00000000 0 00000000 00000000 5
01 0000000 00 00 0F 00000000 00000000 0 00000000 00018000 5
01 0000000 00 00 0D 00000000 00000000 0 00000000 00000000 5
01 0000000 00 00 09 00000000 00000000 0 00000000 00000002 5
02 0000001 00 00 0C 00000000 0000FF00 0 00000000 0000FF02 5
02 0000000 00 00 0C 00000000 00000000 0 00000000 0000FF00 5
02 0010000 08 00 0E 00400100 00000000 1 BFC00380 00000000 7
02 0000000 00 00 0E 00000000 00000000 0 00000000 00400108 5
02 0000000 00 00 0D 00000000 00000000 0 00000000 00000020 5
02 0000000 00 00 0C 00000000 00000000 0 00000000 0000FF02 5
02 0000001 00 00 0C 00000000 0000FF00 0 00000000 0000FF02 5
02 0011000 08 00 0E 00400200 00000000 1 BFC00380 00400108 7
02 0000000 00 00 0E 00000000 00000000 0 00000000 00400204 5
02 0000000 00 00 0D 00000000 00000000 0 00000000 80000020 5
03 0000001 00 00 0C 00000000 0000FF00 0 00000000 0000FF02 5
03 1000100 0C 00 08 00400300 00000000 1 BFC00380 00000000 3
03 0000000 00 00 0E 00000000 00000000 0 00000000 00400300 5
03 0000000 00 00 0D 00000000 00000000 0 00000000 00000030 5
03 0000001 00 00 0C 00000000 0000FF00 0 00000000 0000FF02 5
03 1000000 00 00 0E 00400402 00000000 1 BFC00380 00400300 7
03 0000000 00 00 08 00000000 00000000 0 00000000 0040040E 5
03 0000000 00 00 0D 00000000 00000000 0 00000000 00000010 5
03 0000000 00 00 0E 00000000 00000000 0 00000000 0040040E 5
04 0010000 09 00 0E 00400500 00000000 1 BFC00380 0040040E 7
04 0000000 00 00 0E 00000000 00000000 0 00000000 0040040E 5
04 0000000 00 00 0D 00000000 00000000 0 00000000 00000010 5
04 0010000 1F 00 0C 00400600 00000000 1 0040040E 0000FF02 7
04 0000000 00 00 0C 00000000 00000000 0 00000000 0000FF00 5
05 0000001 00 00 0B 00000000 00000006 0 00000000 00000000 5
05 0000001 00 00 09 00000000 00000004 0 00000000 0000000F 5
05 0000001 00 00 0C 00000000 0000FF01 0 00000000 0000FF00 5
05 0000000 00 00 09 00000000 00000000 0 00000000 00000005 5
05 0000000 00 00 09 00000000 00000000 0 00000000 00000005 5
05 0000000 00 00 09 00000000 00000000 0 00000000 00000006 5
05 0000000 00 00 0D 00400700 00000000 1 BFC00380 00000010 7
05 0000000 00 00 0D 00000000 00000000 0 00000000 00008000 5
05 0000000 00 00 0E 00000000 00000000 0 00000000 00400700 5
05 0000001 00 00 0B 00000000 00000100 0 00000000 00000006 5
05 0000000 00 00 0B 00000000 00000000 0 00000000 00000100 5
05 0000000 00 00 0D 00000000 00000000 0 00000000 00000000 5
06 0000001 00 00 0C 00000000 0000FB01 0 00000000 0000FF03 5
06 0000000 00 01 0D 00000000 00000000 0 00000000 00000000 5
06 0000000 00 01 0D 00000000 00000000 0 00000000 00000400 5
06 0000000 00 02 0D 00400800 00000000 1 BFC00380 00000400 7
06 0000000 00 00 0D 00000000 00000000 0 00000000 00000800 5
06 0000000 00 00 0E 00000000 00000000 0 00000000 00400800 5

// File: project.f
verilog/cp0Pkg.sv
verilog/excPkg.sv
verilog/interruptUnit.sv
verilog/exceptionArbiter.sv
verilog/exceptionController.sv
verilog/cp0Top.sv
dv/cp0Checker.sv
dv/cp0Tb.sv

// File: Makefile
SOURCES := $(shell cat project.f)

obj_dir/Vcp0Tb: project.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/100ps --top-module cp0Tb -f project.f

run: obj_dir/Vcp0Tb
	./obj_dir/Vcp0Tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: dv/cp0Tb.sv
module cp0Tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int wordsPerLine = 11;
    localparam int maxLines = 128;

    logic clk;
    logic reset;
    logic fetchExc;
    logic [31:0] fetchPC;
    logic fetchBD;
    logic decodeExc;
    logic [4:0] decodeCause;
    logic [31:0] decodePC;
    logic decodeBD;
    logic memExc;
    logic [4:0] memCause;
    logic [31:0] memPC;
    logic memBD;
    logic [31:0] memBadVAddr;
    logic [5:0] extInt;
    logic cp0Write;
    logic [4:0] cp0Number;
    logic [31:0] cp0WriteData;
    logic [31:0] cp0ReadData;
    logic jump;
    logic [31:0] jumpAddress;

    logic checking;
    logic [31:0] testNumber;
    logic [2:0] checkMask;
    logic expJump;
    logic [31:0] expJumpAddress;
    logic [31:0] expReadData;
    int passCount;
    int failCount;

    logic [31:0] tests [0:wordsPerLine*maxLines-1];
    int lineCount;
    int cycleLimit;
    int cycle;

    cp0Top u_dut (
        .clk(clk),
        .reset(reset),
        .fetchExc(fetchExc),
        .fetchPC(fetchPC),
        .fetchBD(fetchBD),
        .decodeExc(decodeExc),
        .decodeCause(decodeCause),
        .decodePC(decodePC),
        .decodeBD(decodeBD),
        .memExc(memExc),
        .memCause(memCause),
        .memPC(memPC),
        .memBD(memBD),
        .memBadVAddr(memBadVAddr),
        .extInt(extInt),
        .cp0Write(cp0Write),
        .cp0Number(cp0Number),
        .cp0WriteData(cp0WriteData),
        .cp0ReadData(cp0ReadData),
        .jump(jump),
        .jumpAddress(jumpAddress)
    );

    cp0Checker u_checker (
        .clk(clk),
        .checking(checking),
        .testNumber(testNumber),
        .checkMask(checkMask),
        .expJump(expJump),
        .expJumpAddress(expJumpAddress),
        .expReadData(expReadData),
        .jump(jump),
        .jumpAddress(jumpAddress),
        .cp0ReadData(cp0ReadData),
        .passCount(passCount),
        .failCount(failCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic clearInputs();
        fetchExc = 1'b0;
        fetchPC = 32'd0;
        fetchBD = 1'b0;
        decodeExc = 1'b0;
        decodeCause = 5'd0;
        decodePC = 32'd0;
        decodeBD = 1'b0;
        memExc = 1'b0;
        memCause = 5'd0;
        memPC = 32'd0;
        memBD = 1'b0;
        memBadVAddr = 32'd0;
        extInt = 6'd0;
        cp0Write = 1'b0;
        cp0Number = 5'd0;
        cp0WriteData = 32'd0;
        testNumber = 32'd0;
        checkMask = 3'd0;
        expJump = 1'b0;
        expJumpAddress = 32'd0;
        expReadData = 32'd0;
    endtask

    // Decode and fetch sit two and three instructions behind memory.
    task automatic applyLine(input int line);
        int base;
        logic [31:0] ctl;
        logic [31:0] pc;
        base = line * wordsPerLine;
        ctl = tests[base + 1];
        pc = tests[base + 5];
        testNumber = tests[base];
        fetchExc = ctl[24];
        fetchBD = ctl[20];
        decodeExc = ctl[16];
        decodeBD = ctl[12];
        memExc = ctl[8];
        memBD = ctl[4];
        cp0Write = ctl[0];
        decodeCause = tests[base + 2][4:0];
        memCause = tests[base + 2][4:0];
        extInt = tests[base + 3][5:0];
        cp0Number = tests[base + 4][4:0];
        memPC = pc;
        decodePC = pc + 32'd8;
        fetchPC = pc + 32'd12;
        memBadVAddr = pc + 32'h100;
        cp0WriteData = tests[base + 6];
        expJump = tests[base + 7][0];
        expJumpAddress = tests[base + 8];
        expReadData = tests[base + 9];
        checkMask = tests[base + 10][2:0];
    endtask

    initial begin
        int i;
        int line;
        clearInputs();
        checking = 1'b0;
        reset = 1'b1;
        for (i = 0; i < wordsPerLine * maxLines; i++) begin
            tests[i] = 32'hFFFFFFFF;
        end
        $readmemh("dv/cp0Tests.txt", tests);
        lineCount = 0;
        while (lineCount < maxLines && tests[lineCount * wordsPerLine] != 32'hFFFFFFFF) begin
            lineCount++;
        end
        cycleLimit = lineCount + 20;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        checking = 1'b1;
        for (line = 0; line < lineCount; line++) begin
            applyLine(line);
            @(posedge clk);
            #1;
        end
        checking = 1'b0;
        clearInputs();
        repeat (2) @(posedge clk);
        if (lineCount == 0) begin
            $display("no test lines were read from dv/cp0Tests.txt");
        end
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0 && lineCount > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        cycle = 0;
        do begin
            @(posedge clk);
            cycle++;
        end while (cycle <= cycleLimit);
        $display("timeout after %0d cycles, the tests did not finish", cycle);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: dv/cp0Checker.sv
module cp0Checker (
    input  logic clk,
    input  logic checking,
    input  logic [31:0] testNumber,
    input  logic [2:0] checkMask,
    input  logic expJump,
    input  logic [31:0] expJumpAddress,
    input  logic [31:0] expReadData,
    input  logic jump,
    input  logic [31:0] jumpAddress,
    input  logic [31:0] cp0ReadData,
    output int passCount,
    output int failCount
);

    timeunit 1ns;
    timeprecision 100ps;

    logic testOpen;
    logic [31:0] currentTest;
    int testErrors;

    initial begin
        passCount = 0;
        failCount = 0;
        testOpen = 1'b0;
        currentTest = 32'd0;
        testErrors = 0;
    end

    task automatic closeTest();
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d passed", currentTest);
        end else begin
            failCount++;
            $display("test %0d failed with %0d mismatches", currentTest, testErrors);
        end
        testOpen = 1'b0;
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            testErrors++;
        end
    endtask

    // Outputs are compared at the falling edge.
    always @(negedge clk) begin
        if (testOpen && (!checking || testNumber != currentTest)) begin
            closeTest();
        end
        if (checking) begin
            if (!testOpen) begin
                testOpen = 1'b1;
                currentTest = testNumber;
                testErrors = 0;
            end
            if (checkMask[0]) begin
                compareValue("jump", {31'd0, jump}, {31'd0, expJump});
            end
            if (checkMask[1]) begin
                compareValue("jumpAddress", jumpAddress, expJumpAddress);
            end
            if (checkMask[2]) begin
                compareValue("cp0ReadData", cp0ReadData, expReadData);
            end
        end
    end

endmodule

// File: verilog/cp0Top.sv
module cp0Top (
    input  logic clk,
    input  logic reset,
    input  logic fetchExc,
    input  logic [31:0] fetchPC,
    input  logic fetchBD,
    input  logic decodeExc,
    input  logic [4:0] decodeCause,
    input  logic [31:0] decodePC,
    input  logic decodeBD,
    input  logic memExc,
    input  logic [4:0] memCause,
    input  logic [31:0] memPC,
    input  logic memBD,
    input  logic [31:0] memBadVAddr,
    input  logic [5:0] extInt,
    input  logic cp0Write,
    input  logic [4:0] cp0Number,
    input  logic [31:0] cp0WriteData,
    output logic [31:0] cp0ReadData,
    output logic jump,
    output logic [31:0] jumpAddress
);

    logic excValid;
    logic [4:0] excCause;
    logic [31:0] excPC;
    logic excBD;
    logic [31:0] excBadVAddr;
    logic intRequest;
    cp0Pkg::cp0Word status;
    logic [1:0] softPending;
    logic [31:0] count;
    logic [31:0] compare;
    logic timerPending;

    exceptionArbiter u_arbiter (
        .fetchExc(fetchExc),
        .fetchPC(fetchPC),
        .fetchBD(fetchBD),
        .decodeExc(decodeExc),
        .decodeCause(decodeCause),
        .decodePC(decodePC),
        .decodeBD(decodeBD),
        .memExc(memExc),
        .memCause(memCause),
        .memPC(memPC),
        .memBD(memBD),
        .memBadVAddr(memBadVAddr),
        .intRequest(intRequest),
        .excValid(excValid),
        .excCause(excCause),
        .excPC(excPC),
        .excBD(excBD),
        .excBadVAddr(excBadVAddr)
    );

    // Count and Compare writes drop out in an exception cycle.
    interruptUnit u_interrupt (
        .clk(clk),
        .reset(reset),
        .status(status),
        .softPending(softPending),
        .extInt(extInt),
        .cp0Write(cp0Write & ~excValid),
        .cp0Number(cp0Number),
        .cp0WriteData(cp0WriteData),
        .count(count),
        .compare(compare),
        .timerPending(timerPending),
        .intRequest(intRequest)
    );

    exceptionController u_controller (
        .clk(clk),
        .reset(reset),
        .excValid(excValid),
        .excCause(excCause),
        .excPC(excPC),
        .excBD(excBD),
        .excBadVAddr(excBadVAddr),
        .cp0Write(cp0Write),
        .cp0Number(cp0Number),
        .cp0WriteData(cp0WriteData),
        .count(count),
        .compare(compare),
        .timerPending(timerPending),
        .extInt(extInt),
        .jump(jump),
        .jumpAddress(jumpAddress),
        .status(status),
        .softPending(softPending),
        .cp0ReadData(cp0ReadData)
    );

endmodule

// File: verilog/exceptionController.sv
module exceptionController (
    input  logic clk,
    input  logic reset,
    input  logic excValid,
    input  logic [4:0] excCause,
    input  logic [31:0] excPC,
    input  logic excBD,
    input  logic [31:0] excBadVAddr,
    input  logic cp0Write,
    input  logic [4:0] cp0Number,
    input  cp0Pkg::cp0Word cp0WriteData,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic timerPending,
    input  logic [5:0] extInt,
    output logic jump,
    output logic [31:0] jumpAddress,
    output cp0Pkg::cp0Word status,
    output logic [1:0] softPending,
    output cp0Pkg::cp0Word cp0ReadData
);

    cp0Pkg::cp0Word statusReg;
    cp0Pkg::cp0Word causeReg;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic isEret;
    logic enterHandler;
    logic leaveHandler;
    logic softWrite;
    logic isAddressError;
    logic [5:0] hardwarePending;

    assign isEret = (excCause == excPkg::causeEret);
    assign isAddressError = (excCause == excPkg::causeAdEL) || (excCause == excPkg::causeAdES);

    // A new exception is only recorded outside the handler.
    assign enterHandler = excValid && !statusReg.status.exl && !isEret;
    assign leaveHandler = excValid && statusReg.status.exl && isEret;

    // Exceptions take precedence over an mtc0 in the same cycle.
    assign softWrite = cp0Write && !excValid;

    // Redirect happens in the cycle of the strobe.
    always_comb begin
        jump = excValid;
        jumpAddress = excPkg::handlerVector;
        if (isEret) begin
            jumpAddress = epc;
        end
    end

    assign hardwarePending = {timerPending | extInt[5], extInt[4:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            statusReg.raw <= cp0Pkg::statusResetValue;
            causeReg.raw <= cp0Pkg::causeResetValue;
            epc <= cp0Pkg::epcResetValue;
        end else begin
            causeReg.cause.ip[7:2] <= hardwarePending;
            if (enterHandler) begin
                causeReg.cause.excCode <= excCause;
                causeReg.cause.bd <= excBD;
                statusReg.status.exl <= 1'b1;
                if (excBD) begin
                    // Restart at the branch that owns the delay slot.
                    epc <= excPC - 32'd4;
                end else begin
                    epc <= excPC;
                end
            end else if (leaveHandler) begin
                statusReg.status.exl <= 1'b0;
            end else if (softWrite) begin
                case (cp0Number)
                    cp0Pkg::statusNumber: statusReg <= cp0WriteData;
                    cp0Pkg::causeNumber: causeReg.cause.ip[1:0] <= cp0WriteData.cause.ip[1:0];
                    cp0Pkg::epcNumber: epc <= cp0WriteData.raw;
                    default: ;
                endcase
            end
        end
    end

    // Only meaningful after an address error.
    always_ff @(posedge clk) begin
        if (enterHandler && isAddressError) begin
            badVAddr <= excBadVAddr;
        end else if (softWrite && cp0Number == cp0Pkg::badVAddrNumber) begin
            badVAddr <= cp0WriteData.raw;
        end
    end

    assign status = statusReg;
    assign softPending = causeReg.cause.ip[1:0];

    always_comb begin
        cp0ReadData.raw = 32'd0;
        case (cp0Number)
            cp0Pkg::statusNumber: cp0ReadData = statusReg;
            cp0Pkg::causeNumber: cp0ReadData = causeReg;
            cp0Pkg::epcNumber: cp0ReadData.raw = epc;
            cp0Pkg::badVAddrNumber: cp0ReadData.raw = badVAddr;
            cp0Pkg::countNumber: cp0ReadData.raw = count;
            cp0Pkg::compareNumber: cp0ReadData.raw = compare;
            cp0Pkg::prIdNumber: cp0ReadData.raw = cp0Pkg::prIdValue;
            default: ;
        endcase
    end

endmodule

// File: verilog/exceptionArbiter.sv
module exceptionArbiter (
    input  logic fetchExc,
    input  logic [31:0] fetchPC,
    input  logic fetchBD,
    input  logic decodeExc,
    input  logic [4:0] decodeCause,
    input  logic [31:0] decodePC,
    input  logic decodeBD,
    input  logic memExc,
    input  logic [4:0] memCause,
    input  logic [31:0] memPC,
    input  logic memBD,
    input  logic [31:0] memBadVAddr,
    input  logic intRequest,
    output logic excValid,
    output logic [4:0] excCause,
    output logic [31:0] excPC,
    output logic excBD,
    output logic [31:0] excBadVAddr
);

    // Oldest stage wins. Interrupts only fill an otherwise idle cycle.
    always_comb begin
        excValid = 1'b0;
        excCause = excPkg::causeInt;
        // An interrupt is taken on the next instruction to retire.
        excPC = memPC;
        excBD = memBD;
        excBadVAddr = 32'd0;
        if (memExc) begin
            excValid = 1'b1;
            excCause = memCause;
            excPC = memPC;
            excBD = memBD;
            if (memCause == excPkg::causeAdEL || memCause == excPkg::causeAdES) begin
                excBadVAddr = memBadVAddr;
            end
        end else if (decodeExc) begin
            excValid = 1'b1;
            excCause = decodeCause;
            excPC = decodePC;
            excBD = decodeBD;
        end else if (fetchExc) begin
            // Fetch only raises a misaligned instruction address.
            excValid = 1'b1;
            excCause = excPkg::causeAdEL;
            excPC = fetchPC;
            excBD = fetchBD;
            excBadVAddr = fetchPC;
        end else if (intRequest) begin
            excValid = 1'b1;
        end
    end

endmodule

// File: verilog/interruptUnit.sv
module interruptUnit (
    input  logic clk,
    input  logic reset,
    input  cp0Pkg::cp0Word status,
    input  logic [1:0] softPending,
    input  logic [5:0] extInt,
    input  logic cp0Write,
    input  logic [4:0] cp0Number,
    input  logic [31:0] cp0WriteData,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic timerPending,
    output logic intRequest
);

    logic countPhase;
    logic countWrite;
    logic compareWrite;
    logic [7:0] pendingSources;
    logic [7:0] unmasked;

    assign countWrite = cp0Write && (cp0Number == cp0Pkg::countNumber);
    assign compareWrite = cp0Write && (cp0Number == cp0Pkg::compareNumber);

    // Count advances on every other edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            countPhase <= 1'b0;
            count <= cp0Pkg::countResetValue;
        end else begin
            countPhase <= ~countPhase;
            if (countWrite) begin
                count <= cp0WriteData;
            end else if (countPhase) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= cp0Pkg::compareResetValue;
        end else if (compareWrite) begin
            compare <= cp0WriteData;
        end
    end

    // Timer flag holds until software rewrites Compare.
    always_ff @(posedge clk) begin
        if (reset) begin
            timerPending <= 1'b0;
        end else if (compareWrite) begin
            timerPending <= 1'b0;
        end else if ((count == compare) && (compare != 32'd0)) begin
            timerPending <= 1'b1;
        end
    end

    // Timer shares line 7 with the top hardware line.
    assign pendingSources = {timerPending | extInt[5], extInt[4:0], softPending};
    assign unmasked = pendingSources & status.status.im;

    assign intRequest = status.status.ie && !status.status.exl && (|unmasked);

endmodule

// File: verilog/excPkg.sv
package excPkg;

    // ExcCode values stored in Cause.
    localparam logic [4:0] causeInt = 5'd0;
    localparam logic [4:0] causeAdEL = 5'd4;
    localparam logic [4:0] causeAdES = 5'd5;
    localparam logic [4:0] causeSys = 5'd8;
    localparam logic [4:0] causeBp = 5'd9;
    localparam logic [4:0] causeRI = 5'd10;
    localparam logic [4:0] causeOv = 5'd12;

    // Decode raises the return from handler like a cause.
    // Only redirects to EPC and is never written into Cause.
    localparam logic [4:0] causeEret = 5'd31;

    // General exception entry point.
    localparam logic [31:0] handlerVector = 32'hBFC00380;

endpackage

// File: verilog/cp0Pkg.sv
package cp0Pkg;

    // CP0 register numbers.
    localparam logic [4:0] badVAddrNumber = 5'd8;
    localparam logic [4:0] countNumber = 5'd9;
    localparam logic [4:0] compareNumber = 5'd11;
    localparam logic [4:0] statusNumber = 5'd12;
    localparam logic [4:0] causeNumber = 5'd13;
    localparam logic [4:0] epcNumber = 5'd14;
    localparam logic [4:0] prIdNumber = 5'd15;

    // Read-only processor id.
    localparam logic [31:0] prIdValue = 32'h00018000;

    // Status comes up with EXL set, IE clear and every IM bit open.
    localparam logic [31:0] statusResetValue = 32'h0000FF02;
    localparam logic [31:0] causeResetValue = 32'h00000000;
    localparam logic [31:0] epcResetValue = 32'h00000000;
    localparam logic [31:0] countResetValue = 32'h00000000;
    localparam logic [31:0] compareResetValue = 32'h00000000;

    typedef struct packed {
        logic [15:0] reservedHigh;
        logic [7:0] im;
        logic [5:0] reservedLow;
        logic exl;
        logic ie;
    } statusFields;

    typedef struct packed {
        logic bd;
        logic [14:0] reservedHigh;
        logic [7:0] ip;
        logic reservedMid;
        logic [4:0] excCode;
        logic [1:0] reservedLow;
    } causeFields;

    // One CP0 data word read as Status or as Cause by register number.
    typedef union packed {
        logic [31:0] raw;
        statusFields status;
        causeFields cause;
    } cp0Word;

endpackage
